//--- rs_isa_pkg.sv
/*
 * Instruction and bus formats
 * Shared by the reservation station, the dispatcher and the execute stage
 */
package rs_isa_pkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------
    localparam int TAG_W     = 6;
    localparam int PC_W      = 32;
    localparam int ROB_IDX_W = 5;

    // Physical register tag
    typedef logic [TAG_W-1:0] tag_t;

    // Target functional-unit class
    typedef enum logic [2:0] {
        FU_ALU,
        FU_MULT,
        FU_LOAD,
        FU_STORE,
        FU_BRANCH
    } fu_class_e;

    // One ready bit per unit class, set means any number of issues taken
    typedef struct packed {
        logic alu;
        logic mult;
        logic load;
        logic store;
        logic branch;
    } fu_ready_t;

    // ----------------------------------------
    // Dispatch, CDB and issue records
    // ----------------------------------------
    typedef struct packed {
        fu_class_e             fu;
        tag_t                  dest_tag;
        tag_t                  src1_tag;
        logic                  src1_ready;
        tag_t                  src2_tag;
        logic                  src2_ready;
        logic [PC_W-1:0]       pc;
        logic [ROB_IDX_W-1:0]  rob_idx;
    } dp_inst_t;

    // Tag of a completed result
    typedef struct packed {
        logic valid;
        tag_t tag;
    } cdb_t;

    typedef struct packed {
        logic                  valid;
        fu_class_e             fu;
        tag_t                  dest_tag;
        tag_t                  src1_tag;
        tag_t                  src2_tag;
        logic [PC_W-1:0]       pc;
        logic [PC_W-1:0]       npc;
        logic [ROB_IDX_W-1:0]  rob_idx;
    } is_inst_t;

endpackage

//--- rs_cfg_pkg.sv
/*
 * Reservation station organization
 * Default sizes and the per-entry record
 */
package rs_cfg_pkg;

    // ----------------------------------------
    // Default sizes
    // ----------------------------------------
    // Entries held in the station
    localparam int ENTRY_NUM_DEF = 8;
    // Dispatch slots per cycle
    localparam int DP_NUM_DEF    = 2;
    // Issue channels per cycle
    localparam int IS_NUM_DEF    = 2;
    // CDB broadcasts per cycle
    localparam int CDB_NUM_DEF   = 2;

    // ----------------------------------------
    // Entry record
    // ----------------------------------------
    typedef struct packed {
        logic                 valid;
        rs_isa_pkg::dp_inst_t inst;
    } rs_entry_t;

endpackage

//--- prio_enc_mult.sv
/*
 * Multi-output priority encoder
 * Reports the OUT_NUM lowest set request bits in ascending order
 */
module prio_enc_mult #(
    parameter int IN_W    = 8,
    parameter int OUT_NUM = 2
) (
    input  logic [IN_W-1:0]                        req_i,
    output logic [OUT_NUM-1:0][$clog2(IN_W)-1:0]   idx_o,
    output logic [OUT_NUM-1:0]                     valid_o
);

    localparam int IDX_W = $clog2(IN_W);

    // ----------------------------------------
    // Ascending scan
    // ----------------------------------------
    always_comb begin
        int unsigned found;

        found   = 0;
        // Unused outputs stay invalid with index zero
        idx_o   = '0;
        valid_o = '0;
        for (int i = 0; i < IN_W; i++) begin
            // Next free output takes this bit
            if (req_i[i] && (found < OUT_NUM)) begin
                idx_o[found]   = IDX_W'(i);
                valid_o[found] = 1'b1;
                found          = found + 1;
            end
        end
    end

endmodule

//--- rs_alloc.sv
/*
 * Reservation station allocator
 * Picks free entries for dispatch, routes dispatched instructions,
 * and tracks occupancy for the available-entry count
 */
module rs_alloc #(
    parameter int ENTRY_NUM = rs_cfg_pkg::ENTRY_NUM_DEF,
    parameter int DP_NUM    = rs_cfg_pkg::DP_NUM_DEF,
    parameter int IS_NUM    = rs_cfg_pkg::IS_NUM_DEF
) (
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    input  logic                                     flush_i,
    input  rs_cfg_pkg::rs_entry_t [ENTRY_NUM-1:0]    entries_i,
    input  logic [ENTRY_NUM-1:0]                     is_sel_i,
    input  logic [$clog2(DP_NUM+1)-1:0]              dp_num_i,
    input  rs_isa_pkg::dp_inst_t  [DP_NUM-1:0]       dp_inst_i,
    output logic [ENTRY_NUM-1:0]                     dp_sel_o,
    output rs_isa_pkg::dp_inst_t  [ENTRY_NUM-1:0]    dp_route_o,
    output logic [$clog2(DP_NUM+1)-1:0]              avail_num_o
);

    localparam int IDX_W = $clog2(ENTRY_NUM);
    localparam int OCC_W = $clog2(ENTRY_NUM + 1);
    localparam int DPN_W = $clog2(DP_NUM + 1);
    localparam int ISN_W = $clog2(IS_NUM + 1);

    logic [ENTRY_NUM-1:0]             free_vec;
    logic [DP_NUM-1:0][IDX_W-1:0]     free_idx;
    logic [DP_NUM-1:0]                free_vld;
    logic [OCC_W-1:0]                 occ_q;
    logic [OCC_W-1:0]                 free_cnt;
    logic [ISN_W-1:0]                 is_cnt;

    // ----------------------------------------
    // Free entry search
    // ----------------------------------------
    // Issuing entry counts as free, refilled at the same edge
    always_comb begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            free_vec[e] = ~entries_i[e].valid | is_sel_i[e];
        end
    end

    prio_enc_mult #(
        .IN_W    (ENTRY_NUM),
        .OUT_NUM (DP_NUM)
    ) free_enc_i (
        .req_i   (free_vec),
        .idx_o   (free_idx),
        .valid_o (free_vld)
    );

    // Slot k goes to the k-th free entry
    always_comb begin
        dp_sel_o   = '0;
        dp_route_o = '0;
        for (int k = 0; k < DP_NUM; k++) begin
            if (free_vld[k] && (k < int'(dp_num_i))) begin
                dp_sel_o[free_idx[k]]   = 1'b1;
                dp_route_o[free_idx[k]] = dp_inst_i[k];
            end
        end
    end

    // ----------------------------------------
    // Occupancy and available count
    // ----------------------------------------
    // Entries leaving this cycle
    always_comb begin
        is_cnt = '0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            is_cnt = is_cnt + ISN_W'(is_sel_i[e]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            occ_q <= '0;
        end else begin
            occ_q <= occ_q + OCC_W'(dp_num_i) - OCC_W'(is_cnt);
        end
    end

    // Free after this cycle's issues, capped at the dispatch width
    assign free_cnt = OCC_W'(ENTRY_NUM) - occ_q + OCC_W'(is_cnt);

    always_comb begin
        if (int'(free_cnt) >= DP_NUM) begin
            avail_num_o = DPN_W'(DP_NUM);
        end else begin
            avail_num_o = DPN_W'(free_cnt);
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Dispatcher honours the count it was given
    a_dp_within_avail: assert property (
        @(posedge clk_i) disable iff (rst_i) int'(dp_num_i) <= int'(avail_num_o)
    ) else $error("dispatch of %0d exceeds available %0d", dp_num_i, avail_num_o);

    a_occ_bound: assert property (
        @(posedge clk_i) disable iff (rst_i) int'(occ_q) <= ENTRY_NUM
    ) else $error("occupancy %0d above entry count", occ_q);

endmodule

//--- rs_entry_array.sv
/*
 * Reservation station entry storage
 * Flush, dispatch write, CDB tag wakeup and clear on issue
 */
module rs_entry_array #(
    parameter int ENTRY_NUM = rs_cfg_pkg::ENTRY_NUM_DEF,
    parameter int CDB_NUM   = rs_cfg_pkg::CDB_NUM_DEF
) (
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    input  logic                                     flush_i,
    input  logic [ENTRY_NUM-1:0]                     dp_sel_i,
    input  rs_isa_pkg::dp_inst_t  [ENTRY_NUM-1:0]    dp_route_i,
    input  rs_isa_pkg::cdb_t      [CDB_NUM-1:0]      cdb_i,
    input  logic [ENTRY_NUM-1:0]                     is_sel_i,
    output rs_cfg_pkg::rs_entry_t [ENTRY_NUM-1:0]    entries_o
);

    import rs_cfg_pkg::*;

    rs_entry_t [ENTRY_NUM-1:0]  entries_q;
    logic [ENTRY_NUM-1:0]       hit1;
    logic [ENTRY_NUM-1:0]       hit2;
    logic [ENTRY_NUM-1:0]       vld_vec;

    // ----------------------------------------
    // Wakeup comparators
    // ----------------------------------------
    // Each source matched against every valid broadcast
    always_comb begin
        hit1 = '0;
        hit2 = '0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            for (int c = 0; c < CDB_NUM; c++) begin
                if (cdb_i[c].valid) begin
                    if (cdb_i[c].tag == entries_q[e].inst.src1_tag) begin
                        hit1[e] = 1'b1;
                    end
                    if (cdb_i[c].tag == entries_q[e].inst.src2_tag) begin
                        hit2[e] = 1'b1;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Entry update
    // ----------------------------------------
    // Flush beats dispatch, dispatch beats issue clear
    // Issue beats wakeup since the entry leaves anyway
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            if (rst_i || flush_i) begin
                entries_q[e].valid <= 1'b0;
            end else if (dp_sel_i[e]) begin
                entries_q[e].valid <= 1'b1;
                entries_q[e].inst  <= dp_route_i[e];
            end else if (is_sel_i[e]) begin
                entries_q[e].valid <= 1'b0;
            end else if (entries_q[e].valid) begin
                // Sources wake independently
                if (hit1[e]) begin
                    entries_q[e].inst.src1_ready <= 1'b1;
                end
                if (hit2[e]) begin
                    entries_q[e].inst.src2_ready <= 1'b1;
                end
            end
        end
    end

    assign entries_o = entries_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    always_comb begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            vld_vec[e] = entries_q[e].valid;
        end
    end

    // Allocator never overwrites a live entry
    a_dp_to_free: assert property (
        @(posedge clk_i) disable iff (rst_i) (dp_sel_i & vld_vec & ~is_sel_i) == '0
    ) else $error("dispatch into occupied entry %b", dp_sel_i & vld_vec & ~is_sel_i);

endmodule

//--- rs_issue_select.sv
/*
 * Reservation station issue select
 * Ready check against unit availability, lowest-index selection,
 * and routing onto the issue channels
 */
module rs_issue_select #(
    parameter int ENTRY_NUM = rs_cfg_pkg::ENTRY_NUM_DEF,
    parameter int IS_NUM    = rs_cfg_pkg::IS_NUM_DEF
) (
    input  rs_cfg_pkg::rs_entry_t [ENTRY_NUM-1:0]    entries_i,
    input  rs_isa_pkg::fu_ready_t                    fu_ready_i,
    output logic [ENTRY_NUM-1:0]                     is_sel_o,
    output rs_isa_pkg::is_inst_t  [IS_NUM-1:0]       is_inst_o
);

    import rs_isa_pkg::*;

    localparam int IDX_W = $clog2(ENTRY_NUM);

    logic [ENTRY_NUM-1:0]           rdy_vec;
    logic [IS_NUM-1:0][IDX_W-1:0]   sel_idx;
    logic [IS_NUM-1:0]              sel_vld;

    // ----------------------------------------
    // Ready check
    // ----------------------------------------
    always_comb begin
        logic fu_ok;

        for (int e = 0; e < ENTRY_NUM; e++) begin
            // Unit class of this entry
            case (entries_i[e].inst.fu)
                FU_ALU:    fu_ok = fu_ready_i.alu;
                FU_MULT:   fu_ok = fu_ready_i.mult;
                FU_LOAD:   fu_ok = fu_ready_i.load;
                FU_STORE:  fu_ok = fu_ready_i.store;
                FU_BRANCH: fu_ok = fu_ready_i.branch;
                default:   fu_ok = 1'b0;
            endcase
            rdy_vec[e] = entries_i[e].valid && entries_i[e].inst.src1_ready &&
                         entries_i[e].inst.src2_ready && fu_ok;
        end
    end

    // Lowest index wins
    prio_enc_mult #(
        .IN_W    (ENTRY_NUM),
        .OUT_NUM (IS_NUM)
    ) issue_enc_i (
        .req_i   (rdy_vec),
        .idx_o   (sel_idx),
        .valid_o (sel_vld)
    );

    // ----------------------------------------
    // Issue routing
    // ----------------------------------------
    always_comb begin
        is_sel_o  = '0;
        is_inst_o = '0;
        for (int c = 0; c < IS_NUM; c++) begin
            if (sel_vld[c]) begin
                is_sel_o[sel_idx[c]]  = 1'b1;
                is_inst_o[c].valid    = 1'b1;
                is_inst_o[c].fu       = entries_i[sel_idx[c]].inst.fu;
                is_inst_o[c].dest_tag = entries_i[sel_idx[c]].inst.dest_tag;
                is_inst_o[c].src1_tag = entries_i[sel_idx[c]].inst.src1_tag;
                is_inst_o[c].src2_tag = entries_i[sel_idx[c]].inst.src2_tag;
                is_inst_o[c].pc       = entries_i[sel_idx[c]].inst.pc;
                // Sequential next pc
                is_inst_o[c].npc      = entries_i[sel_idx[c]].inst.pc + PC_W'(4);
                is_inst_o[c].rob_idx  = entries_i[sel_idx[c]].inst.rob_idx;
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Two channels never carry the same entry
    always_comb begin
        for (int a = 0; a < IS_NUM; a++) begin
            for (int b = a + 1; b < IS_NUM; b++) begin
                a_one_channel: assert (!(sel_vld[a] && sel_vld[b] && (sel_idx[a] == sel_idx[b])))
                    else $error("entry %0d issued on channels %0d and %0d", sel_idx[a], a, b);
            end
        end
    end

endmodule

//--- rs_top.sv
/*
 * Reservation station top level
 * Connects allocator, entry storage and issue select
 */
module rs_top #(
    parameter int ENTRY_NUM = rs_cfg_pkg::ENTRY_NUM_DEF,
    parameter int DP_NUM    = rs_cfg_pkg::DP_NUM_DEF,
    parameter int IS_NUM    = rs_cfg_pkg::IS_NUM_DEF,
    parameter int CDB_NUM   = rs_cfg_pkg::CDB_NUM_DEF
) (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 flush_i,
    input  logic [$clog2(DP_NUM+1)-1:0]          dp_num_i,
    input  rs_isa_pkg::dp_inst_t [DP_NUM-1:0]    dp_inst_i,
    input  rs_isa_pkg::cdb_t     [CDB_NUM-1:0]   cdb_i,
    input  rs_isa_pkg::fu_ready_t                fu_ready_i,
    output logic [$clog2(DP_NUM+1)-1:0]          avail_num_o,
    output rs_isa_pkg::is_inst_t [IS_NUM-1:0]    is_inst_o
);

    import rs_isa_pkg::*;
    import rs_cfg_pkg::*;

    // Registered entries, read by allocator and select
    rs_entry_t [ENTRY_NUM-1:0]  entries;
    logic [ENTRY_NUM-1:0]       is_sel;
    logic [ENTRY_NUM-1:0]       dp_sel;
    dp_inst_t  [ENTRY_NUM-1:0]  dp_route;

    // ----------------------------------------
    // Allocation
    // ----------------------------------------
    rs_alloc #(
        .ENTRY_NUM (ENTRY_NUM),
        .DP_NUM    (DP_NUM),
        .IS_NUM    (IS_NUM)
    ) alloc_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .entries_i   (entries),
        .is_sel_i    (is_sel),
        .dp_num_i    (dp_num_i),
        .dp_inst_i   (dp_inst_i),
        .dp_sel_o    (dp_sel),
        .dp_route_o  (dp_route),
        .avail_num_o (avail_num_o)
    );

    // ----------------------------------------
    // Storage and wakeup
    // ----------------------------------------
    rs_entry_array #(
        .ENTRY_NUM (ENTRY_NUM),
        .CDB_NUM   (CDB_NUM)
    ) array_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .dp_sel_i   (dp_sel),
        .dp_route_i (dp_route),
        .cdb_i      (cdb_i),
        .is_sel_i   (is_sel),
        .entries_o  (entries)
    );

    // ----------------------------------------
    // Issue
    // ----------------------------------------
    rs_issue_select #(
        .ENTRY_NUM (ENTRY_NUM),
        .IS_NUM    (IS_NUM)
    ) select_i (
        .entries_i  (entries),
        .fu_ready_i (fu_ready_i),
        .is_sel_o   (is_sel),
        .is_inst_o  (is_inst_o)
    );

endmodule

//--- tb_rs.sv
/*
 * Reservation station testbench
 * Directed dispatch, wakeup, FU gating, issue order, flush and reuse tests
 */
module tb_rs;

    import rs_isa_pkg::*;
    import rs_cfg_pkg::*;

    typedef logic [$clog2(DP_NUM_DEF+1)-1:0] cnt_t;

    localparam int CLK_PERIOD = 10;
    // Cycles per test: reset, fill, wakeup, gating, order, flush, reuse
    localparam int RUN_CYCLES = 2 + 8 + 9 + 8 + 8 + 11 + 14;
    localparam int MARGIN     = 40;

    logic                       clk_i;
    logic                       rst_i;
    logic                       flush_i;
    cnt_t                       dp_num;
    dp_inst_t [DP_NUM_DEF-1:0]  dp_inst;
    cdb_t     [CDB_NUM_DEF-1:0] cdb;
    fu_ready_t                  fu_ready;
    cnt_t                       avail_num;
    is_inst_t [IS_NUM_DEF-1:0]  is_inst;
    int                         err_cnt;
    int                         seed;

    rs_top dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .dp_num_i    (dp_num),
        .dp_inst_i   (dp_inst),
        .cdb_i       (cdb),
        .fu_ready_i  (fu_ready),
        .avail_num_o (avail_num),
        .is_inst_o   (is_inst)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Watchdog
    initial begin
        #((RUN_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Timeout, tests still running after %0d cycles", RUN_CYCLES + MARGIN);
        $display("sim failed");
        $finish;
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_fu(input string name, input fu_class_e exp, input fu_class_e act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name());
            err_cnt++;
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_pc(input string name, input logic [PC_W-1:0] exp,
                            input logic [PC_W-1:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_rob(input string name, input logic [ROB_IDX_W-1:0] exp,
                             input logic [ROB_IDX_W-1:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input cnt_t exp, input cnt_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    // Valid issue channels this cycle
    function automatic cnt_t issue_count();
        cnt_t n;
        n = '0;
        for (int c = 0; c < IS_NUM_DEF; c++) begin
            n = n + cnt_t'(is_inst[c].valid);
        end
        return n;
    endfunction

    // Only the given unit class ready
    function automatic fu_ready_t fu_only(input fu_class_e fu);
        fu_ready_t r;
        r = '0;
        case (fu)
            FU_ALU:    r.alu    = 1'b1;
            FU_MULT:   r.mult   = 1'b1;
            FU_LOAD:   r.load   = 1'b1;
            FU_STORE:  r.store  = 1'b1;
            default:   r.branch = 1'b1;
        endcase
        return r;
    endfunction

    function automatic dp_inst_t make_inst(input fu_class_e fu, input logic rdy,
                                           input logic [PC_W-1:0] pc);
        dp_inst_t inst;
        inst.fu         = fu;
        inst.dest_tag   = tag_t'($random(seed));
        inst.src1_tag   = tag_t'($random(seed));
        // Distinct sources, each needs its own broadcast
        inst.src2_tag   = inst.src1_tag + tag_t'(1);
        inst.src1_ready = rdy;
        inst.src2_ready = rdy;
        inst.pc         = pc;
        inst.rob_idx    = pc[6:2];
        return inst;
    endfunction

    // Quiet inputs, FU readiness untouched
    task automatic drive_idle();
        flush_i <= 1'b0;
        dp_num  <= '0;
        dp_inst <= '0;
        cdb     <= '0;
    endtask

    task automatic clear_station();
        @(posedge clk_i);
        drive_idle();
        flush_i  <= 1'b1;
        fu_ready <= '0;
        @(posedge clk_i);
        drive_idle();
    endtask

    // Two per cycle until full, first instruction may differ in class
    task automatic fill_station(input string name, input fu_class_e first_fu,
                                input fu_class_e rest_fu, input logic rdy);
        for (int i = 0; i < ENTRY_NUM_DEF / DP_NUM_DEF; i++) begin
            @(posedge clk_i);
            dp_num     <= cnt_t'(DP_NUM_DEF);
            dp_inst[0] <= make_inst((i == 0) ? first_fu : rest_fu, rdy, PC_W'(32'h100 + i * 8));
            dp_inst[1] <= make_inst(rest_fu, rdy, PC_W'(32'h104 + i * 8));
            @(negedge clk_i);
            check_count({name, " avail while filling"}, cnt_t'(DP_NUM_DEF), avail_num);
            check_count({name, " no issue while filling"}, '0, issue_count());
        end
        @(posedge clk_i);
        drive_idle();
    endtask

    task automatic wait_for_issue(input string name, input int max_cycles);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!is_inst[0].valid && n < max_cycles) begin
            @(negedge clk_i);
            n++;
        end
        if (!is_inst[0].valid) begin
            $display("%s: no instruction issued within %0d cycles", name, max_cycles);
            err_cnt++;
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_fill();
        check_count("reset_fill avail after reset", cnt_t'(DP_NUM_DEF), avail_num);
        check_count("reset_fill no issue after reset", '0, issue_count());
        fill_station("reset_fill", FU_ALU, FU_ALU, 1'b0);
        @(negedge clk_i);
        check_count("reset_fill avail when full", '0, avail_num);
        check_count("reset_fill no issue when full", '0, issue_count());
    endtask

    task automatic test_wakeup_issue();
        dp_inst_t inst;
        clear_station();
        inst = make_inst(FU_ALU, 1'b0, 32'h0000_2000);
        @(posedge clk_i);
        fu_ready   <= fu_only(FU_ALU);
        dp_num     <= cnt_t'(1);
        dp_inst[0] <= inst;
        // First source on CDB lane 0
        @(posedge clk_i);
        drive_idle();
        cdb[0] <= '{1'b1, inst.src1_tag};
        @(negedge clk_i);
        check_count("wakeup_issue waits on both sources", '0, issue_count());
        // Second source on lane 1
        @(posedge clk_i);
        drive_idle();
        cdb[1] <= '{1'b1, inst.src2_tag};
        @(negedge clk_i);
        check_count("wakeup_issue waits on second source", '0, issue_count());
        @(posedge clk_i);
        drive_idle();
        @(negedge clk_i);
        check_count("wakeup_issue issues after broadcasts", cnt_t'(1), issue_count());
        check_fu("wakeup_issue fu", FU_ALU, is_inst[0].fu);
        check_tag("wakeup_issue dest tag", inst.dest_tag, is_inst[0].dest_tag);
        check_tag("wakeup_issue src1 tag", inst.src1_tag, is_inst[0].src1_tag);
        check_tag("wakeup_issue src2 tag", inst.src2_tag, is_inst[0].src2_tag);
        check_pc("wakeup_issue pc", inst.pc, is_inst[0].pc);
        check_pc("wakeup_issue npc", inst.pc + 32'd4, is_inst[0].npc);
        check_rob("wakeup_issue rob idx", inst.rob_idx, is_inst[0].rob_idx);
        @(negedge clk_i);
        check_count("wakeup_issue entry gone", '0, issue_count());
    endtask

    task automatic test_fu_gating();
        fu_ready_t rdy;
        clear_station();
        @(posedge clk_i);
        dp_num     <= cnt_t'(2);
        dp_inst[0] <= make_inst(FU_MULT, 1'b1, 32'h0000_3000);
        dp_inst[1] <= make_inst(FU_LOAD, 1'b1, 32'h0000_3004);
        @(posedge clk_i);
        drive_idle();
        rdy = fu_only(FU_LOAD);
        fu_ready <= rdy;
        @(negedge clk_i);
        check_count("fu_gating only load issues", cnt_t'(1), issue_count());
        check_fu("fu_gating load", FU_LOAD, is_inst[0].fu);
        check_pc("fu_gating load pc", 32'h0000_3004, is_inst[0].pc);
        @(negedge clk_i);
        check_count("fu_gating mult waits", '0, issue_count());
        // Raise mult, issue in the same cycle
        @(posedge clk_i);
        rdy.mult = 1'b1;
        fu_ready <= rdy;
        @(negedge clk_i);
        check_count("fu_gating mult issues", cnt_t'(1), issue_count());
        check_fu("fu_gating mult", FU_MULT, is_inst[0].fu);
        check_pc("fu_gating mult pc", 32'h0000_3000, is_inst[0].pc);
    endtask

    task automatic test_issue_order();
        clear_station();
        @(posedge clk_i);
        dp_num     <= cnt_t'(2);
        dp_inst[0] <= make_inst(FU_ALU, 1'b1, 32'h0000_4000);
        dp_inst[1] <= make_inst(FU_ALU, 1'b1, 32'h0000_4004);
        @(posedge clk_i);
        drive_idle();
        dp_num     <= cnt_t'(1);
        dp_inst[0] <= make_inst(FU_ALU, 1'b1, 32'h0000_4008);
        @(posedge clk_i);
        drive_idle();
        fu_ready <= fu_only(FU_ALU);
        @(negedge clk_i);
        check_count("issue_order two issue", cnt_t'(2), issue_count());
        check_pc("issue_order channel 0", 32'h0000_4000, is_inst[0].pc);
        check_pc("issue_order channel 1", 32'h0000_4004, is_inst[1].pc);
        check_rob("issue_order channel 1 rob idx", 5'd1, is_inst[1].rob_idx);
        @(negedge clk_i);
        check_count("issue_order third issues", cnt_t'(1), issue_count());
        check_pc("issue_order third pc", 32'h0000_4008, is_inst[0].pc);
        check_rob("issue_order third rob idx", 5'd2, is_inst[0].rob_idx);
        @(negedge clk_i);
        check_count("issue_order station empty", '0, issue_count());
    endtask

    task automatic test_flush();
        clear_station();
        fill_station("flush", FU_ALU, FU_ALU, 1'b1);
        @(negedge clk_i);
        check_count("flush avail when full", '0, avail_num);
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i  <= 1'b0;
        fu_ready <= '1;
        @(negedge clk_i);
        check_count("flush avail restored", cnt_t'(DP_NUM_DEF), avail_num);
        check_count("flush no issue", '0, issue_count());
        @(negedge clk_i);
        check_count("flush still no issue", '0, issue_count());
    endtask

    task automatic test_reuse();
        clear_station();
        // Entry 0 ALU, the rest LOAD
        fill_station("reuse", FU_ALU, FU_LOAD, 1'b1);
        @(posedge clk_i);
        fu_ready   <= fu_only(FU_ALU);
        dp_num     <= cnt_t'(1);
        dp_inst[0] <= make_inst(FU_BRANCH, 1'b1, 32'h0000_6000);
        @(negedge clk_i);
        check_count("reuse avail with one issuing", cnt_t'(1), avail_num);
        check_count("reuse one issue", cnt_t'(1), issue_count());
        check_fu("reuse alu leaves", FU_ALU, is_inst[0].fu);
        @(posedge clk_i);
        drive_idle();
        @(negedge clk_i);
        check_count("reuse full again", '0, avail_num);
        check_count("reuse branch waits", '0, issue_count());
        @(posedge clk_i);
        fu_ready <= fu_only(FU_BRANCH);
        wait_for_issue("reuse", 4);
        check_fu("reuse branch issues", FU_BRANCH, is_inst[0].fu);
        check_pc("reuse branch pc", 32'h0000_6000, is_inst[0].pc);
    endtask

    // ----------------------------------------
    // Sequence
    // ----------------------------------------
    initial begin
        seed     = 32'h55f0;
        err_cnt  = 0;
        rst_i    = 1'b1;
        flush_i  = 1'b0;
        dp_num   = '0;
        dp_inst  = '0;
        cdb      = '0;
        fu_ready = '0;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        test_reset_fill();
        test_wakeup_issue();
        test_fu_gating();
        test_issue_order();
        test_flush();
        test_reuse();
        $display("Tests done with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- project.f
rs_isa_pkg.sv
rs_cfg_pkg.sv
prio_enc_mult.sv
rs_alloc.sv
rs_entry_array.sv
rs_issue_select.sv
rs_top.sv
tb_rs.sv

//--- run.sh
#!/bin/sh
# Build the reservation station testbench with Verilator, run it, check the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_rs -o tb_rs_sim \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/tb_rs_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
